/* design/cache_cpu_side.sv */
module cache_cpu_side
  import snowball_pkg::*;
(
  input  logic             CPU_CLK,
  input  logic             RST,
  input  addr_t            cpu_addr,
  input  data_t            cpu_wdata,
  input  logic             cpu_we,
  input  logic             cpu_req,
  input  logic             tlb_write,
  input  logic             vmem_act,
  input  logic             cache_inhibit,
  output data_t            cpu_rdata,
  output logic             busy,
  output logic             mmu_fault,
  output logic             lookup_re,
  output logic [IDX_W-1:0] lookup_idx,
  output logic [IDX_W-1:0] tlb_idx,
  input  data_t            data_rd,
  input  cache_tag_t       tag_rd,
  input  page_tag_t        tlb_phys_rd,
  input  page_tag_t        tlb_virt_rd,
  output logic             launch_toggle,
  output addr_t            req_addr,
  output data_t            req_wdata,
  output logic             req_we,
  output logic             req_tlb,
  output cache_tag_t       fill_tag,
  input  logic             retire_toggle,
  input  data_t            fill_data
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOOKUP,                          // ram read
    ST_COMPARE,                         // tag and tlb compare
    ST_RESOLVE,                         // hit, fault or launch
    ST_MEMWAIT                          // waiting for mem side retire
  } state_t;

  state_t           state;
  addr_t            addr_q;
  logic             req_vmem;
  page_tag_t        vpage;
  page_tag_t        page_tag;
  cache_tag_t       lookup_tag;
  logic             tag_hit;
  logic             tlb_miss;
  logic             hit_q;
  logic             fault_q;
  data_t            data_q;
  logic             plain_read;
  logic             accept;
  logic [CACHE_LINES-1:0] line_valid;
  logic [2:0]       retire_sync;
  logic             retire_edge;

  // --------------------------------------------------------------------------
  // lookup datapath
  // --------------------------------------------------------------------------
  assign accept = (state == ST_IDLE) && ((cpu_req && !cache_inhibit) || tlb_write);
  assign busy = (state != ST_IDLE);
  assign lookup_re = (state == ST_LOOKUP);
  assign lookup_idx = addr_q[WORD_IDX_LSB +: IDX_W];
  assign tlb_idx = addr_q[TLB_IDX_LSB +: IDX_W];
  assign vpage = addr_q[PAGE_TAG_LSB +: PAGE_W];
  assign plain_read = !req_we && !req_tlb;

  // tlb writes are never translated
  assign page_tag = (req_vmem && !req_tlb) ? tlb_phys_rd : vpage;
  assign lookup_tag = {page_tag, tlb_idx};
  assign tag_hit = line_valid[lookup_idx] && (tag_rd == lookup_tag);
  assign tlb_miss = req_vmem && !req_tlb && (tlb_virt_rd != vpage);

  assign retire_edge = retire_sync[2] ^ retire_sync[1];
  assign req_addr = {fill_tag, addr_q[TLB_IDX_LSB-1:0]}; // physical address

  // request fields and returned data
  always_ff @(posedge CPU_CLK)
  begin
    if (accept)
    begin
      addr_q <= cpu_addr;
      req_wdata <= cpu_wdata;
      req_we <= cpu_we && !tlb_write;
      req_tlb <= tlb_write;
      req_vmem <= vmem_act;
    end
    if (state == ST_COMPARE)
    begin
      fill_tag <= lookup_tag;
      data_q <= data_rd;
    end
    if ((state == ST_RESOLVE) && hit_q && !fault_q && plain_read)
    begin
      cpu_rdata <= data_q;              // hit
    end
    else if ((state == ST_MEMWAIT) && retire_edge && plain_read)
    begin
      cpu_rdata <= fill_data;           // miss fill
    end
  end

  // --------------------------------------------------------------------------
  // request FSM
  // --------------------------------------------------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      state <= ST_IDLE;
      launch_toggle <= 1'b0;
      mmu_fault <= 1'b0;
      line_valid <= '0;
      retire_sync <= '0;
      hit_q <= 1'b0;
      fault_q <= 1'b0;
    end
    else
    begin
      retire_sync <= {retire_sync[1:0], retire_toggle}; // two flops plus edge stage
      case (state)
        ST_IDLE:
        begin
          if (accept)
          begin
            mmu_fault <= 1'b0;
            state <= ST_LOOKUP;
          end
        end
        ST_LOOKUP:
        begin
          state <= ST_COMPARE;
        end
        ST_COMPARE:
        begin
          hit_q <= tag_hit;
          fault_q <= tlb_miss;
          state <= ST_RESOLVE;
        end
        ST_RESOLVE:
        begin
          if (fault_q)
          begin
            mmu_fault <= 1'b1;          // no memory access
            state <= ST_IDLE;
          end
          else if (hit_q && plain_read)
          begin
            state <= ST_IDLE;
          end
          else
          begin
            launch_toggle <= !launch_toggle; // miss, write or tlb write
            state <= ST_MEMWAIT;
          end
        end
        ST_MEMWAIT:
        begin
          if (retire_edge)
          begin
            if (!req_tlb)
            begin
              line_valid[lookup_idx] <= 1'b1; // line now filled or written
            end
            state <= ST_IDLE;
          end
        end
        default:
        begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

/* design/cache_mem_side.sv */
module cache_mem_side
  import snowball_pkg::*;
(
  input  logic             mcu_clk,
  input  logic             RST,
  input  logic             launch_toggle,
  input  addr_t            req_addr,
  input  data_t            req_wdata,
  input  logic             req_we,
  input  logic             req_tlb,
  input  cache_tag_t       fill_tag,
  output logic             retire_toggle,
  output data_t            fill_data,
  output addr_t            mem_addr,
  output logic             mem_we,
  output data_t            mem_wdata,
  output logic             mem_req,
  input  logic             mem_grant,
  input  logic             mem_ack,
  input  data_t            mem_rdata,
  output logic             data_we,
  output logic [IDX_W-1:0] data_waddr,
  output data_t            data_wdata,
  output cache_tag_t       tag_wdata,
  output logic             tlb_we,
  output logic [IDX_W-1:0] tlb_waddr
);

  logic [2:0] launch_sync;
  logic       launch_edge;
  logic       pending;                  // transaction waiting for ack
  logic       op_write;
  logic       op_tlb;
  logic       done;

  // --------------------------------------------------------------------------
  // memory port
  // --------------------------------------------------------------------------
  assign launch_edge = launch_sync[2] ^ launch_sync[1];
  assign mem_req = pending && mem_grant; // arbiter holds off the request
  assign done = mem_req && mem_ack;

  // write data for writes and tlb entries, read data for fills
  assign data_wdata = (op_write || op_tlb) ? mem_wdata : mem_rdata;

  // cache and tlb ram write ports
  assign data_we = done && !op_tlb;
  assign tlb_we = done && op_tlb;
  assign data_waddr = mem_addr[WORD_IDX_LSB +: IDX_W];
  assign tlb_waddr = mem_addr[WORD_IDX_LSB +: IDX_W]; // entry index from bits 9:2

  // fields are held stable by the cpu side until retire
  always_ff @(posedge mcu_clk)
  begin
    if (launch_edge)
    begin
      mem_addr <= req_addr;
      mem_wdata <= req_wdata;
      tag_wdata <= fill_tag;
    end
    if (done)
    begin
      fill_data <= data_wdata;
    end
  end

  // --------------------------------------------------------------------------
  // transaction control
  // --------------------------------------------------------------------------
  always_ff @(posedge mcu_clk)
  begin
    if (!RST)
    begin
      launch_sync <= '0;
      pending <= 1'b0;
      op_write <= 1'b0;
      op_tlb <= 1'b0;
      mem_we <= 1'b0;
      retire_toggle <= 1'b0;
    end
    else
    begin
      launch_sync <= {launch_sync[1:0], launch_toggle};
      if (launch_edge)
      begin
        pending <= 1'b1;
        op_write <= req_we;
        op_tlb <= req_tlb;
        mem_we <= req_we || req_tlb;    // tlb entries go out as writes
      end
      else if (done)
      begin
        pending <= 1'b0;
        mem_we <= 1'b0;
        retire_toggle <= !retire_toggle; // back to the cpu side
      end
    end
  end

endmodule

/* design/dual_clock_ram.sv */
module dual_clock_ram #(
  parameter type payload_t = logic [31:0],
  parameter int  DEPTH = 256
) (
  input  logic       wclk,
  input  logic       we,
  input  logic [7:0] waddr,
  input  payload_t   wdata,
  input  logic       rclk,
  input  logic       re,
  input  logic [7:0] raddr,
  output payload_t   rdata
);

  payload_t mem [DEPTH];                // storage array

  // write port, memory clock domain
  always_ff @(posedge wclk)
  begin
    if (we)
    begin
      mem[waddr] <= wdata;
    end
  end

  // read port, registered output
  always_ff @(posedge rclk)
  begin
    if (re)
    begin
      rdata <= mem[raddr];
    end
  end

endmodule

/* design/snowball_cache.sv */
module snowball_cache
  import snowball_pkg::*;
(
  input  logic  CPU_CLK,
  input  logic  mcu_clk,
  input  logic  RST,
  input  addr_t cpu_addr,
  input  data_t cpu_wdata,
  input  logic  cpu_we,
  input  logic  cpu_req,
  input  logic  tlb_write,
  input  logic  vmem_act,
  input  logic  cache_inhibit,
  output data_t cpu_rdata,
  output logic  busy,
  output logic  mmu_fault,
  output addr_t mem_addr,
  output logic  mem_we,
  output data_t mem_wdata,
  output logic  mem_req,
  input  logic  mem_grant,
  input  logic  mem_ack,
  input  data_t mem_rdata
);

  logic             lookup_re;
  logic [IDX_W-1:0] lookup_idx;
  logic [IDX_W-1:0] tlb_idx;
  data_t            data_rd;
  cache_tag_t       tag_rd;
  page_tag_t        tlb_phys_rd;
  page_tag_t        tlb_virt_rd;
  logic             launch_toggle;
  addr_t            req_addr;
  data_t            req_wdata;
  logic             req_we;
  logic             req_tlb;
  cache_tag_t       fill_tag;
  logic             retire_toggle;
  data_t            fill_data;
  logic             data_we;
  logic [IDX_W-1:0] data_waddr;
  data_t            data_wdata;
  cache_tag_t       tag_wdata;
  logic             tlb_we;
  logic [IDX_W-1:0] tlb_waddr;

  // --------------------------------------------------------------------------
  // clock domain sides
  // --------------------------------------------------------------------------
  cache_cpu_side u_cpu_side (
    .CPU_CLK       (CPU_CLK),
    .RST           (RST),
    .cpu_addr      (cpu_addr),
    .cpu_wdata     (cpu_wdata),
    .cpu_we        (cpu_we),
    .cpu_req       (cpu_req),
    .tlb_write     (tlb_write),
    .vmem_act      (vmem_act),
    .cache_inhibit (cache_inhibit),
    .cpu_rdata     (cpu_rdata),
    .busy          (busy),
    .mmu_fault     (mmu_fault),
    .lookup_re     (lookup_re),
    .lookup_idx    (lookup_idx),
    .tlb_idx       (tlb_idx),
    .data_rd       (data_rd),
    .tag_rd        (tag_rd),
    .tlb_phys_rd   (tlb_phys_rd),
    .tlb_virt_rd   (tlb_virt_rd),
    .launch_toggle (launch_toggle),
    .req_addr      (req_addr),
    .req_wdata     (req_wdata),
    .req_we        (req_we),
    .req_tlb       (req_tlb),
    .fill_tag      (fill_tag),
    .retire_toggle (retire_toggle),
    .fill_data     (fill_data)
  );

  cache_mem_side u_mem_side (
    .mcu_clk       (mcu_clk),
    .RST           (RST),
    .launch_toggle (launch_toggle),
    .req_addr      (req_addr),
    .req_wdata     (req_wdata),
    .req_we        (req_we),
    .req_tlb       (req_tlb),
    .fill_tag      (fill_tag),
    .retire_toggle (retire_toggle),
    .fill_data     (fill_data),
    .mem_addr      (mem_addr),
    .mem_we        (mem_we),
    .mem_wdata     (mem_wdata),
    .mem_req       (mem_req),
    .mem_grant     (mem_grant),
    .mem_ack       (mem_ack),
    .mem_rdata     (mem_rdata),
    .data_we       (data_we),
    .data_waddr    (data_waddr),
    .data_wdata    (data_wdata),
    .tag_wdata     (tag_wdata),
    .tlb_we        (tlb_we),
    .tlb_waddr     (tlb_waddr)
  );

  // --------------------------------------------------------------------------
  // storage, written on mcu_clk and read on CPU_CLK
  // --------------------------------------------------------------------------
  dual_clock_ram #(.payload_t(data_t), .DEPTH(CACHE_LINES)) u_cache_data (
    .wclk (mcu_clk), .we (data_we), .waddr (data_waddr), .wdata (data_wdata),
    .rclk (CPU_CLK), .re (lookup_re), .raddr (lookup_idx), .rdata (data_rd)
  );

  dual_clock_ram #(.payload_t(cache_tag_t), .DEPTH(CACHE_LINES)) u_cache_tag (
    .wclk (mcu_clk), .we (data_we), .waddr (data_waddr), .wdata (tag_wdata),
    .rclk (CPU_CLK), .re (lookup_re), .raddr (lookup_idx), .rdata (tag_rd)
  );

  // tlb halves come straight from the entry word
  dual_clock_ram #(.payload_t(page_tag_t), .DEPTH(TLB_ENTRIES)) u_tlb_phys (
    .wclk  (mcu_clk),
    .we    (tlb_we),
    .waddr (tlb_waddr),
    .wdata (data_wdata[TLB_ENTRY_PHYS_MSB -: PAGE_W]),
    .rclk  (CPU_CLK),
    .re    (lookup_re),
    .raddr (tlb_idx),
    .rdata (tlb_phys_rd)
  );

  dual_clock_ram #(.payload_t(page_tag_t), .DEPTH(TLB_ENTRIES)) u_tlb_virt (
    .wclk  (mcu_clk),
    .we    (tlb_we),
    .waddr (tlb_waddr),
    .wdata (data_wdata[TLB_ENTRY_VIRT_MSB -: PAGE_W]),
    .rclk  (CPU_CLK),
    .re    (lookup_re),
    .raddr (tlb_idx),
    .rdata (tlb_virt_rd)
  );

endmodule

/* design/snowball_pkg.sv */
package snowball_pkg;

  // --------------------------------------------------------------------------
  // address layout
  // --------------------------------------------------------------------------
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int IDX_W = 8;              // cache and tlb index width
  localparam int PAGE_W = 14;            // virtual and physical page tag width

  localparam int WORD_IDX_LSB = 2;       // word index at 9:2
  localparam int TLB_IDX_LSB = 10;       // tlb index at 17:10
  localparam int PAGE_TAG_LSB = 18;      // page tag at 31:18

  // --------------------------------------------------------------------------
  // storage depths
  // --------------------------------------------------------------------------
  localparam int CACHE_LINES = 256;
  localparam int TLB_ENTRIES = 256;

  // tlb entry word as written through the memory port
  localparam int TLB_ENTRY_PHYS_MSB = 29; // physical tag 29:16
  localparam int TLB_ENTRY_VIRT_MSB = 13; // virtual tag 13:0

  // --------------------------------------------------------------------------
  // types
  // --------------------------------------------------------------------------
  typedef logic [ADDR_W-1:0] addr_t;    // byte address
  typedef logic [DATA_W-1:0] data_t;    // data word
  typedef logic [PAGE_W-1:0] page_tag_t;

  // cache line tag, physical page plus the tlb index bits of the address
  typedef struct packed {
    page_tag_t          ppage;
    logic [IDX_W-1:0]   tidx;
  } cache_tag_t;

endpackage

/* run_sim.sh */
#!/usr/bin/env bash
# compile the cache testbench with Verilator, run it and scan the log
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --top-module tb_snowball_cache \
  -f tb.f --Mdir "$build_dir" -o sim_snowball
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$build_dir/sim_snowball" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^TEST PASSED$" "$log_file"; then
  exit 0
fi
echo "pass message not found in $log_file"
exit 1

/* tb.f */
design/snowball_pkg.sv
design/dual_clock_ram.sv
design/cache_cpu_side.sv
design/cache_mem_side.sv
design/snowball_cache.sv
testbench/tb_clock.sv
testbench/tb_mem_model.sv
testbench/tb_snowball_cache.sv

/* testbench/tb_clock.sv */
module tb_clock (
  output logic CPU_CLK,
  output logic mcu_clk,
  output logic RST
);

  initial
  begin
    CPU_CLK = 1'b0;
    forever #10 CPU_CLK = !CPU_CLK;      // period 20
  end

  initial
  begin
    mcu_clk = 1'b0;
    forever #13 mcu_clk = !mcu_clk;      // period 26, unrelated to CPU_CLK
  end

  // reset low for 4 cpu cycles, released on a falling edge
  initial
  begin
    RST = 1'b0;
    repeat (4) @(posedge CPU_CLK);
    @(negedge CPU_CLK);
    RST = 1'b1;
  end

endmodule

/* testbench/tb_mem_model.sv */
module tb_mem_model
  import snowball_pkg::*;
(
  input  logic       mcu_clk,
  input  logic       RST,
  input  addr_t      mem_addr,
  input  logic       mem_we,
  input  data_t      mem_wdata,
  input  logic       mem_req,
  output logic       mem_ack,
  output data_t      mem_rdata,
  input  logic [1:0] ack_delay,
  output int         access_count
);

  data_t      mem [addr_t];              // sparse word store, keyed by word address
  logic       ack_q = 1'b0;
  data_t      rdata_q = '0;
  logic [1:0] wait_cnt = '0;
  int         count_q = 0;

  assign mem_ack = ack_q;
  assign mem_rdata = rdata_q;
  assign access_count = count_q;

  function automatic addr_t word_of(addr_t a);
    return {a[31:2], 2'b00};
  endfunction

  // words never loaded follow a pattern of the whole address
  function automatic data_t peek(addr_t a);
    if (mem.exists(word_of(a)))
    begin
      return mem[word_of(a)];
    end
    return {a[15:0], a[31:16]} ^ 32'h3c96_a55a;
  endfunction

  function automatic void poke(addr_t a, data_t d);
    mem[word_of(a)] = d;
  endfunction

  // --------------------------------------------------------------------------
  // memory port, one ack pulse per access after ack_delay cycles
  // --------------------------------------------------------------------------
  always @(posedge mcu_clk)
  begin
    if (!RST)
    begin
      ack_q <= 1'b0;
      wait_cnt <= '0;
      count_q <= 0;
    end
    else if (ack_q)
    begin
      ack_q <= 1'b0;                     // single cycle ack
    end
    else if (mem_req)
    begin
      if (wait_cnt == ack_delay)
      begin
        ack_q <= 1'b1;
        wait_cnt <= '0;
        count_q <= count_q + 1;
        if (mem_we)
        begin
          mem[word_of(mem_addr)] = mem_wdata;
        end
        else
        begin
          rdata_q <= peek(mem_addr);
        end
      end
      else
      begin
        wait_cnt <= wait_cnt + 2'd1;
      end
    end
  end

endmodule

/* testbench/tb_snowball_cache.sv */
module tb_snowball_cache
  import snowball_pkg::*;
();

  logic        CPU_CLK;
  logic        mcu_clk;
  logic        RST;
  addr_t       cpu_addr;
  data_t       cpu_wdata;
  logic        cpu_we;
  logic        cpu_req;
  logic        tlb_write;
  logic        vmem_act;
  logic        cache_inhibit;
  data_t       cpu_rdata;
  logic        busy;
  logic        mmu_fault;
  addr_t       mem_addr;
  logic        mem_we;
  data_t       mem_wdata;
  logic        mem_req;
  logic        mem_grant;
  logic        mem_ack;
  data_t       mem_rdata;
  logic [1:0]  ack_delay;
  int          access_count;
  logic [31:0] lfsr_state;

  tb_clock u_clock (.CPU_CLK (CPU_CLK), .mcu_clk (mcu_clk), .RST (RST));

  tb_mem_model u_mem (
    .mcu_clk      (mcu_clk),
    .RST          (RST),
    .mem_addr     (mem_addr),
    .mem_we       (mem_we),
    .mem_wdata    (mem_wdata),
    .mem_req      (mem_req),
    .mem_ack      (mem_ack),
    .mem_rdata    (mem_rdata),
    .ack_delay    (ack_delay),
    .access_count (access_count)
  );

  snowball_cache DUT (
    .CPU_CLK       (CPU_CLK),
    .mcu_clk       (mcu_clk),
    .RST           (RST),
    .cpu_addr      (cpu_addr),
    .cpu_wdata     (cpu_wdata),
    .cpu_we        (cpu_we),
    .cpu_req       (cpu_req),
    .tlb_write     (tlb_write),
    .vmem_act      (vmem_act),
    .cache_inhibit (cache_inhibit),
    .cpu_rdata     (cpu_rdata),
    .busy          (busy),
    .mmu_fault     (mmu_fault),
    .mem_addr      (mem_addr),
    .mem_we        (mem_we),
    .mem_wdata     (mem_wdata),
    .mem_req       (mem_req),
    .mem_grant     (mem_grant),
    .mem_ack       (mem_ack),
    .mem_rdata     (mem_rdata)
  );

  // --------------------------------------------------------------------------
  // galois lfsr stepped once per bit taken
  // --------------------------------------------------------------------------
  function automatic logic lfsr_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out)
    begin
      lfsr_state = lfsr_state ^ 32'h8020_0003; // taps 32 22 2 1
    end
    return out;
  endfunction

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++)
    begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  function automatic addr_t make_addr(page_tag_t pg, logic [7:0] ti, logic [7:0] wi);
    return {pg, ti, wi, 2'b00};
  endfunction

  // --------------------------------------------------------------------------
  // checks
  // --------------------------------------------------------------------------
  task automatic abort_run(string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_data(string name, data_t got, data_t exp);
    if (got !== exp)
    begin
      abort_run($sformatf("** Error at %0t: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp)
    begin
      abort_run($sformatf("** Error at %0t: %s is %b, expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_count(string name, int got, int exp);
    if (got != exp)
    begin
      abort_run($sformatf("** Error at %0t: %s is %0d, expected %0d", $time, name, got, exp));
    end
  endtask

  // --------------------------------------------------------------------------
  // bus helpers
  // --------------------------------------------------------------------------
  task automatic load_word(addr_t a);
    u_mem.poke(a, rand_bits(32));
  endtask

  task automatic issue_request(addr_t a, data_t d, logic we, logic tlb);
    logic [31:0] bits;
    bits = rand_bits(2);
    @(negedge CPU_CLK);
    ack_delay = bits[1:0];                 // 0 to 3 cycles
    cpu_addr = a;
    cpu_wdata = d;
    cpu_we = we;
    cpu_req = !tlb;
    tlb_write = tlb;
    @(negedge CPU_CLK);
    cpu_req = 1'b0;
    tlb_write = 1'b0;
    cpu_we = 1'b0;
    if (!busy)
    begin
      abort_run($sformatf("request at %0t was not accepted, busy stayed low", $time));
    end
  endtask

  task automatic wait_idle(output int cycles);
    cycles = 0;
    while (busy)
    begin
      @(negedge CPU_CLK);
      cycles++;
      if (cycles > 200)
      begin
        abort_run("busy did not fall within 200 cycles");
      end
    end
  endtask

  task automatic do_read(addr_t a, output data_t rd, output int cycles);
    issue_request(a, '0, 1'b0, 1'b0);
    wait_idle(cycles);
    rd = cpu_rdata;
  endtask

  // --------------------------------------------------------------------------
  // directed tests
  // --------------------------------------------------------------------------
  task automatic check_reset_state();
    int waited;
    waited = 0;
    while (!RST)
    begin
      @(negedge CPU_CLK);
      waited++;
      if (waited > 20)
      begin
        abort_run("reset was never released");
      end
    end
    @(negedge CPU_CLK);
    check_bit("busy", busy, 1'b0);
    check_bit("mmu_fault", mmu_fault, 1'b0);
    check_bit("mem_req", mem_req, 1'b0);
    check_bit("mem_we", mem_we, 1'b0);
  endtask

  task automatic read_miss_then_hit();
    addr_t a;
    data_t rd;
    int    base;
    int    cycles;
    a = make_addr(14'h0123, 8'h45, 8'h10);
    load_word(a);
    base = access_count;
    do_read(a, rd, cycles);
    check_data("cpu_rdata", rd, u_mem.peek(a));
    check_count("access_count", access_count, base + 1);
    do_read(a, rd, cycles);
    check_data("cpu_rdata", rd, u_mem.peek(a));
    check_count("access_count", access_count, base + 1);
    check_count("hit latency", cycles, 3);
  endtask

  task automatic write_through();
    addr_t a;
    data_t w;
    data_t rd;
    int    base;
    int    cycles;
    a = make_addr(14'h0a0b, 8'h12, 8'h20);
    load_word(a);
    w = rand_bits(32);
    base = access_count;
    issue_request(a, w, 1'b1, 1'b0);
    wait_idle(cycles);
    check_data("model word", u_mem.peek(a), w);
    check_count("access_count", access_count, base + 1);
    do_read(a, rd, cycles);                // served from the cache
    check_data("cpu_rdata", rd, w);
    check_count("access_count", access_count, base + 1);
    check_count("hit latency", cycles, 3);
  endtask

  task automatic index_conflict();
    addr_t a1;
    addr_t a2;
    data_t rd;
    int    base;
    int    cycles;
    a1 = make_addr(14'h1111, 8'h33, 8'h30);
    a2 = make_addr(14'h2222, 8'h33, 8'h30); // same line but another tag
    load_word(a1);
    load_word(a2);
    base = access_count;
    do_read(a1, rd, cycles);
    check_data("cpu_rdata", rd, u_mem.peek(a1));
    do_read(a2, rd, cycles);
    check_data("cpu_rdata", rd, u_mem.peek(a2));
    do_read(a1, rd, cycles);
    check_data("cpu_rdata", rd, u_mem.peek(a1));
    check_count("access_count", access_count, base + 3);
  endtask

  task automatic translation();
    page_tag_t  v;
    page_tag_t  p;
    logic [7:0] ti;
    addr_t      entry_addr;
    data_t      entry;
    addr_t      vaddr;
    addr_t      paddr;
    data_t      rd;
    int         base;
    int         cycles;
    v = 14'h0777;
    p = 14'h1abc;
    ti = 8'h5c;
    entry_addr = make_addr(14'h0001, 8'h00, ti); // entry index in bits 9:2
    entry = {2'b00, p, 2'b00, v};
    vaddr = make_addr(v, ti, 8'h40);
    paddr = make_addr(p, ti, 8'h40);
    load_word(vaddr);
    load_word(paddr);
    @(negedge CPU_CLK);
    vmem_act = 1'b1;
    base = access_count;
    issue_request(entry_addr, entry, 1'b0, 1'b1);
    wait_idle(cycles);
    check_data("model word", u_mem.peek(entry_addr), entry);
    check_count("access_count", access_count, base + 1);
    do_read(vaddr, rd, cycles);
    check_data("cpu_rdata", rd, u_mem.peek(paddr));
    check_bit("mmu_fault", mmu_fault, 1'b0);
    check_count("access_count", access_count, base + 2);
    do_read(vaddr, rd, cycles);
    check_data("cpu_rdata", rd, u_mem.peek(paddr));
    check_count("hit latency", cycles, 3);
    // virtual tag that the entry does not hold
    do_read(make_addr(v ^ 14'h0040, ti, 8'h41), rd, cycles);
    check_bit("mmu_fault", mmu_fault, 1'b1);
    check_count("fault latency", cycles, 3);
    check_count("access_count", access_count, base + 2);
    @(negedge CPU_CLK);
    vmem_act = 1'b0;
  endtask

  task automatic inhibit_and_grant();
    addr_t a;
    data_t rd;
    int    base;
    int    hold;
    int    cycles;
    int    i;
    base = access_count;
    @(negedge CPU_CLK);
    cache_inhibit = 1'b1;
    cpu_req = 1'b1;
    cpu_addr = make_addr(14'h0055, 8'h66, 8'h60);
    for (i = 0; i < 5; i++)
    begin
      @(negedge CPU_CLK);
      check_bit("busy", busy, 1'b0);
    end
    cpu_req = 1'b0;
    cache_inhibit = 1'b0;
    check_count("access_count", access_count, base);

    a = make_addr(14'h3030, 8'h77, 8'h50);
    load_word(a);
    hold = 8 + int'(rand_bits(4));
    @(negedge CPU_CLK);
    mem_grant = 1'b0;                      // arbiter withholds the port
    issue_request(a, '0, 1'b0, 1'b0);
    for (i = 0; i < hold; i++)
    begin
      @(negedge CPU_CLK);
      check_bit("mem_req", mem_req, 1'b0);
      check_bit("busy", busy, 1'b1);
    end
    mem_grant = 1'b1;
    wait_idle(cycles);
    rd = cpu_rdata;
    check_data("cpu_rdata", rd, u_mem.peek(a));
    check_bit("mmu_fault", mmu_fault, 1'b0);
    check_count("access_count", access_count, base + 1);
  endtask

  initial
  begin
    lfsr_state = 32'hf595_92e3;
    cpu_addr = '0;
    cpu_wdata = '0;
    cpu_we = 1'b0;
    cpu_req = 1'b0;
    tlb_write = 1'b0;
    vmem_act = 1'b0;
    cache_inhibit = 1'b0;
    mem_grant = 1'b1;
    ack_delay = 2'd0;

    check_reset_state();
    read_miss_then_hit();
    write_through();
    index_conflict();
    translation();
    inhibit_and_grant();

    $display("TEST PASSED");
    $finish;
  end

endmodule
